// ==== include/lsu_params.svh ====
//////////////////////////////
// Widths and depths of the LSU
// LSU_SQ_DEPTH must be a power of two
//////////////////////////////

`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// Data and address width
`define LSU_DATA_WIDTH 32

// Reorder buffer tag width
`define LSU_TAG_WIDTH 6

// Store queue entries
`define LSU_SQ_DEPTH 4

// Data memory words, address wraps modulo this depth
`define LSU_DMEM_WORDS 64

`endif

// ==== src/lsu_pkg.sv ====
//////////////////////////////
// Types shared across the LSU
// Widths come from lsu_params.svh
//////////////////////////////

`default_nettype none

`include "lsu_params.svh"

package lsu_pkg;

    typedef logic [`LSU_DATA_WIDTH-1:0]   data_t;
    typedef logic [`LSU_DATA_WIDTH-1:0]   addr_t;
    typedef logic [`LSU_TAG_WIDTH-1:0]    tag_t;
    typedef logic [`LSU_DATA_WIDTH/8-1:0] byte_select_t;

    typedef enum logic {
        OPCODE_LOAD,
        OPCODE_STORE
    } lsu_opcode_t;

    // Access type, decoded from funct3 and the opcode
    typedef enum logic [2:0] {
        LSU_LB,
        LSU_LH,
        LSU_LW,
        LSU_LBU,
        LSU_LHU,
        LSU_SB,
        LSU_SH,
        LSU_SW
    } lsu_func_t;

    // Reservation station issue bundle
    typedef struct packed {
        lsu_opcode_t opcode;
        data_t       insn;
        data_t       src_a;
        data_t       src_b;
        tag_t        tag;
    } lsu_issue_t;

    // One access moving through the pipeline or sitting in the store queue
    typedef struct packed {
        lsu_func_t lsu_func;
        addr_t     addr;
        data_t     data;
        tag_t      tag;
        logic      valid;
        logic      retire;
    } lsu_op_t;

    typedef struct packed {
        data_t data;
        addr_t addr;
        tag_t  tag;
    } cdb_t;

endpackage

`default_nettype wire

// ==== src/lsu_id.sv ====
//////////////////////////////
// Decode of issued loads and stores
// Purely combinational
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module lsu_id (
    input  logic                i_valid,
    input  lsu_pkg::lsu_issue_t i_issue,
    input  logic                i_stall,
    output lsu_pkg::lsu_op_t    o_op,
    output logic                o_alloc_en
);

    logic [2:0]         funct3;
    logic               is_store;
    logic               accept;
    logic               func_legal;
    lsu_pkg::lsu_func_t lsu_func;
    lsu_pkg::addr_t     imm;

    assign funct3   = i_issue.insn[14:12];
    assign is_store = (i_issue.opcode == lsu_pkg::OPCODE_STORE);
    assign accept   = i_valid && !i_stall;

    always_comb begin
        func_legal = 1'b1;
        lsu_func   = lsu_pkg::LSU_LW;
        if (is_store) begin
            case (funct3)
                3'b000:  lsu_func = lsu_pkg::LSU_SB;
                3'b001:  lsu_func = lsu_pkg::LSU_SH;
                3'b010:  lsu_func = lsu_pkg::LSU_SW;
                default: begin
                    lsu_func   = lsu_pkg::LSU_SW;
                    func_legal = 1'b0;
                end
            endcase
        end else begin
            case (funct3)
                3'b000:  lsu_func = lsu_pkg::LSU_LB;
                3'b001:  lsu_func = lsu_pkg::LSU_LH;
                3'b010:  lsu_func = lsu_pkg::LSU_LW;
                3'b100:  lsu_func = lsu_pkg::LSU_LBU;
                3'b101:  lsu_func = lsu_pkg::LSU_LHU;
                default: func_legal = 1'b0;
            endcase
        end
    end

    // S-type splits the immediate around rd, I-type keeps it whole
    always_comb begin
        if (is_store) begin
            imm = {{(`LSU_DATA_WIDTH-12){i_issue.insn[31]}},
                   i_issue.insn[31:25], i_issue.insn[11:7]};
        end else begin
            imm = {{(`LSU_DATA_WIDTH-12){i_issue.insn[31]}}, i_issue.insn[31:20]};
        end
    end

    always_comb begin
        o_op.lsu_func = lsu_func;
        o_op.addr     = i_issue.src_a + imm;
        o_op.data     = is_store ? i_issue.src_b : '0;
        o_op.tag      = i_issue.tag;
        o_op.valid    = accept;
        o_op.retire   = 1'b0;
    end

    // Stores also take a queue slot
    assign o_alloc_en = accept && is_store;

    // The reservation station only sends RV32I load/store encodings
    a_funct3_legal: assert final (i_valid !== 1'b1 || func_legal)
        else $error("lsu_id: illegal funct3 %0b for opcode %s", funct3, i_issue.opcode.name());

endmodule

`default_nettype wire

// ==== src/lsu_sq.sv ====
//////////////////////////////
// Store queue, stores wait here for ROB retirement
// Flush drops every entry, retired or not
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module lsu_sq (
    input  logic             clk,
    input  logic             n_rst,
    input  logic             i_flush,
    input  logic             i_alloc_en,
    input  lsu_pkg::lsu_op_t i_alloc,
    input  logic             i_rob_retire_en,
    input  lsu_pkg::tag_t    i_rob_retire_tag,
    output logic             o_full,
    output logic             o_rob_retire_stall,
    output lsu_pkg::lsu_op_t o_retire
);

    localparam int DEPTH = `LSU_SQ_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    lsu_pkg::lsu_op_t entries [DEPTH];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [PTR_W:0]   count_q;
    logic             pending_q;
    logic             retire_accept;
    logic             pop;

    assign o_full = (count_q == (PTR_W+1)'(DEPTH));

    // Only one retire in flight at a time
    assign o_rob_retire_stall = pending_q || (count_q == '0);
    assign retire_accept      = i_rob_retire_en && !o_rob_retire_stall;

    // Head leaves in the cycle after its retire was taken
    assign pop = pending_q;

    always_comb begin
        o_retire        = entries[head_q];
        o_retire.valid  = pending_q;
        o_retire.retire = pending_q;
    end

    always_ff @(posedge clk) begin
        if (i_alloc_en) begin
            entries[tail_q] <= i_alloc;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            head_q    <= '0;
            tail_q    <= '0;
            count_q   <= '0;
            pending_q <= 1'b0;
        end else if (i_flush) begin
            head_q    <= '0;
            tail_q    <= '0;
            count_q   <= '0;
            pending_q <= 1'b0;
        end else begin
            pending_q <= retire_accept;
            if (i_alloc_en) begin
                tail_q <= tail_q + 1'b1;
            end
            if (pop) begin
                head_q <= head_q + 1'b1;
            end
            case ({i_alloc_en, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // ROB retires stores in program order, so it always names the oldest one
    a_retire_in_order: assert property (@(posedge clk) disable iff (!n_rst)
        retire_accept |-> (i_rob_retire_tag == entries[head_q].tag))
        else $error("lsu_sq: retire tag %0d is not the head tag %0d",
                    i_rob_retire_tag, entries[head_q].tag);

    // The top stalls issue while full
    a_no_alloc_full: assert property (@(posedge clk) disable iff (!n_rst)
        i_alloc_en |-> !o_full)
        else $error("lsu_sq: allocation into a full queue");

endmodule

`default_nettype wire

// ==== src/lsu_dmem.sv ====
//////////////////////////////
// Data memory, word addressed, contents not reset
// Address wraps modulo LSU_DMEM_WORDS
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module lsu_dmem (
    input  logic                  clk,
    input  logic                  i_we,
    input  lsu_pkg::addr_t        i_addr,
    input  lsu_pkg::data_t        i_data,
    input  lsu_pkg::byte_select_t i_byte_select,
    output lsu_pkg::data_t        o_data
);

    localparam int WORDS    = `LSU_DMEM_WORDS;
    localparam int IDX_W    = $clog2(WORDS);
    localparam int LANES    = $bits(lsu_pkg::byte_select_t);
    localparam int OFFSET_W = $clog2(LANES);

    lsu_pkg::data_t   mem [WORDS];
    logic [IDX_W-1:0] word_idx;

    // Byte offset bits are dropped, the EX stage handles lanes
    assign word_idx = i_addr[OFFSET_W +: IDX_W];

    assign o_data = mem[word_idx];

    always_ff @(posedge clk) begin
        if (i_we) begin
            for (int i = 0; i < LANES; i++) begin
                if (i_byte_select[i]) begin
                    mem[word_idx][8*i +: 8] <= i_data[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/lsu_ex.sv ====
//////////////////////////////
// Execute stage, accesses must be naturally aligned
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lsu_ex (
    input  logic             clk,
    input  lsu_pkg::lsu_op_t i_op,
    output lsu_pkg::lsu_op_t o_result
);

    logic [1:0]            offset;
    logic [4:0]            shamt;
    logic                  dmem_we;
    logic                  misaligned;
    lsu_pkg::byte_select_t byte_select;
    lsu_pkg::data_t        wdata;
    lsu_pkg::data_t        rdata;
    lsu_pkg::data_t        rdata_shifted;
    lsu_pkg::data_t        load_data;

    assign offset = i_op.addr[1:0];
    assign shamt  = {offset, 3'b000};

    // Only stores launched from the queue touch memory
    assign dmem_we = i_op.valid && i_op.retire;

    always_comb begin
        byte_select = '0;
        misaligned  = 1'b0;
        case (i_op.lsu_func)
            lsu_pkg::LSU_LB, lsu_pkg::LSU_LBU, lsu_pkg::LSU_SB: begin
                byte_select = 4'b0001 << offset;
            end
            lsu_pkg::LSU_LH, lsu_pkg::LSU_LHU, lsu_pkg::LSU_SH: begin
                byte_select = 4'b0011 << offset;
                misaligned  = offset[0];
            end
            default: begin
                byte_select = 4'b1111;
                misaligned  = |offset;
            end
        endcase
    end

    assign wdata         = i_op.data << shamt;
    assign rdata_shifted = rdata >> shamt;

    // Sign or zero extend, stores broadcast zero
    always_comb begin
        case (i_op.lsu_func)
            lsu_pkg::LSU_LB:  load_data = {{24{rdata_shifted[7]}}, rdata_shifted[7:0]};
            lsu_pkg::LSU_LBU: load_data = {24'b0, rdata_shifted[7:0]};
            lsu_pkg::LSU_LH:  load_data = {{16{rdata_shifted[15]}}, rdata_shifted[15:0]};
            lsu_pkg::LSU_LHU: load_data = {16'b0, rdata_shifted[15:0]};
            lsu_pkg::LSU_LW:  load_data = rdata_shifted;
            default:          load_data = '0;
        endcase
    end

    always_comb begin
        o_result.lsu_func = i_op.lsu_func;
        o_result.addr     = i_op.addr;
        o_result.data     = load_data;
        o_result.tag      = i_op.tag;
        o_result.valid    = i_op.valid && !i_op.retire;
        o_result.retire   = 1'b0;
    end

    lsu_dmem lsu_dmem_inst (
        .clk(clk),
        .i_we(dmem_we),
        .i_addr(i_op.addr),
        .i_data(wdata),
        .i_byte_select(byte_select),
        .o_data(rdata)
    );

    // Address comes from decode, so this checks the issued base and immediate
    a_aligned: assert property (@(posedge clk) i_op.valid |-> !misaligned)
        else $error("lsu_ex: misaligned %s at 0x%08h", i_op.lsu_func.name(), i_op.addr);

endmodule

`default_nettype wire

// ==== src/lsu.sv ====
//////////////////////////////
// LSU top, two cycle load and store latency
// No forwarding, loads see retired stores only
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lsu (
    input  logic                clk,
    input  logic                n_rst,
    input  logic                i_flush,
    input  logic                i_fu_valid,
    input  lsu_pkg::lsu_issue_t i_fu_issue,
    output logic                o_fu_stall,
    input  logic                i_rob_retire_en,
    input  lsu_pkg::tag_t       i_rob_retire_tag,
    output logic                o_rob_retire_stall,
    output logic                o_cdb_en,
    output lsu_pkg::cdb_t       o_cdb
);

    lsu_pkg::lsu_op_t id_op;
    lsu_pkg::lsu_op_t sq_retire;
    lsu_pkg::lsu_op_t id_mux;
    lsu_pkg::lsu_op_t id_ex_q;
    lsu_pkg::lsu_op_t ex_op;
    lsu_pkg::lsu_op_t ex_result;
    lsu_pkg::cdb_t    ex_wb_q;
    logic             id_ex_valid_q;
    logic             ex_wb_valid_q;
    logic             alloc_en;
    logic             sq_full;

    // Hold off issue while the queue is full or a store is launching
    assign o_fu_stall = sq_full || sq_retire.valid;

    // Launching store wins, issue is already stalled in that cycle
    assign id_mux = sq_retire.valid ? sq_retire : id_op;

    // ID -> EX
    always_ff @(posedge clk) begin
        id_ex_q <= id_mux;
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            id_ex_valid_q <= 1'b0;
        end else if (i_flush) begin
            id_ex_valid_q <= 1'b0;
        end else begin
            id_ex_valid_q <= id_mux.valid;
        end
    end

    always_comb begin
        ex_op       = id_ex_q;
        ex_op.valid = id_ex_valid_q;
    end

    // EX -> WB
    always_ff @(posedge clk) begin
        ex_wb_q.data <= ex_result.data;
        ex_wb_q.addr <= ex_result.addr;
        ex_wb_q.tag  <= ex_result.tag;
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            ex_wb_valid_q <= 1'b0;
        end else if (i_flush) begin
            ex_wb_valid_q <= 1'b0;
        end else begin
            ex_wb_valid_q <= ex_result.valid;
        end
    end

    assign o_cdb_en = ex_wb_valid_q;
    assign o_cdb    = ex_wb_q;

    lsu_id lsu_id_inst (
        .i_valid(i_fu_valid),
        .i_issue(i_fu_issue),
        .i_stall(o_fu_stall),
        .o_op(id_op),
        .o_alloc_en(alloc_en)
    );

    lsu_sq lsu_sq_inst (
        .clk(clk),
        .n_rst(n_rst),
        .i_flush(i_flush),
        .i_alloc_en(alloc_en),
        .i_alloc(id_op),
        .i_rob_retire_en(i_rob_retire_en),
        .i_rob_retire_tag(i_rob_retire_tag),
        .o_full(sq_full),
        .o_rob_retire_stall(o_rob_retire_stall),
        .o_retire(sq_retire)
    );

    lsu_ex lsu_ex_inst (
        .clk(clk),
        .i_op(ex_op),
        .o_result(ex_result)
    );

endmodule

`default_nettype wire

// ==== verification/lsu_tb.sv ====
//////////////////////////////
// LSU testbench, accesses stay in a 16 word window at address 0
// Model memory changes only when a store is retired
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module lsu_tb;

    typedef struct packed {
        logic [2:0]     funct3;
        lsu_pkg::addr_t addr;
        lsu_pkg::data_t data;
        lsu_pkg::tag_t  tag;
    } pending_store_t;

    logic                clk;
    logic                n_rst;
    logic                i_flush;
    logic                i_fu_valid;
    lsu_pkg::lsu_issue_t i_fu_issue;
    logic                o_fu_stall;
    logic                i_rob_retire_en;
    lsu_pkg::tag_t       i_rob_retire_tag;
    logic                o_rob_retire_stall;
    logic                o_cdb_en;
    lsu_pkg::cdb_t       o_cdb;

    logic [31:0]         rng_state = 32'h2243955f;
    logic [7:0]          model_mem [64];
    logic [2:0]          load_f3 [5] = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
    lsu_pkg::cdb_t       exp_q[$];
    string               name_q[$];
    int                  exp_edge_q[$];
    pending_store_t      store_q[$];
    string               cur_test = "reset";
    int                  edge_cnt = 0;
    int                  last_wait = 0;

    lsu DUT (
        .clk(clk),
        .n_rst(n_rst),
        .i_flush(i_flush),
        .i_fu_valid(i_fu_valid),
        .i_fu_issue(i_fu_issue),
        .o_fu_stall(o_fu_stall),
        .i_rob_retire_en(i_rob_retire_en),
        .i_rob_retire_tag(i_rob_retire_tag),
        .o_rob_retire_stall(o_rob_retire_stall),
        .o_cdb_en(o_cdb_en),
        .o_cdb(o_cdb)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Aligned address inside the window for the access size in funct3
    function automatic lsu_pkg::addr_t random_target(input logic [2:0] funct3);
        lsu_pkg::addr_t a;
        a = next_rand() & 32'h3f;
        case (funct3[1:0])
            2'b00:   return a;
            2'b01:   return a & ~32'h1;
            default: return a & ~32'h3;
        endcase
    endfunction

    // Little endian load from the model, extended per RV32I funct3
    function automatic lsu_pkg::data_t load_ref(input logic [2:0] funct3,
                                                input lsu_pkg::addr_t addr);
        logic [5:0] a;
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        logic [7:0] b3;
        a  = addr[5:0];
        b0 = model_mem[a];
        b1 = model_mem[a + 6'd1];
        b2 = model_mem[a + 6'd2];
        b3 = model_mem[a + 6'd3];
        case (funct3)
            3'b000:  return {{24{b0[7]}}, b0};
            3'b001:  return {{16{b1[7]}}, b1, b0};
            3'b010:  return {b3, b2, b1, b0};
            3'b100:  return {24'b0, b0};
            default: return {16'b0, b1, b0};
        endcase
    endfunction

    function automatic void apply_store(input pending_store_t st);
        for (int i = 0; i < (1 << st.funct3[1:0]); i++) begin
            model_mem[6'(st.addr + i)] = st.data[8*i +: 8];
        end
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_tag(input string name, input lsu_pkg::tag_t exp,
                             input lsu_pkg::tag_t act);
        if (act !== exp) begin
            fail_run($sformatf("[FAIL] %s tag expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_cdb(input string name, input lsu_pkg::cdb_t exp,
                             input lsu_pkg::cdb_t act);
        if (act !== exp) begin
            fail_run($sformatf({"[FAIL] %s cdb expected data=%08h addr=%08h tag=%0d",
                                " actual data=%08h addr=%08h tag=%0d"}, name,
                               exp.data, exp.addr, exp.tag, act.data, act.addr, act.tag));
        end
    endtask

    // Broadcasts must come out in acceptance order
    always @(negedge clk) begin : compare_cdb
        lsu_pkg::cdb_t want;
        string         name;
        if (n_rst === 1'b1 && o_cdb_en !== 1'b0) begin
            if (exp_q.size() == 0) begin
                fail_run("DUT broadcast on the CDB while no result was expected");
            end else begin
                want = exp_q.pop_front();
                name = name_q.pop_front();
                void'(exp_edge_q.pop_front());
                check_tag(name, want.tag, o_cdb.tag);
                check_cdb(name, want, o_cdb);
            end
        end
    end

    // Called 1 ns after an edge, returns 1 ns after the accepting edge
    task automatic issue_op(input bit is_store, input logic [2:0] funct3,
                            input lsu_pkg::addr_t target, input lsu_pkg::data_t wdata);
        logic [31:0]         rnd;
        logic [11:0]         imm12;
        lsu_pkg::addr_t      imm;
        lsu_pkg::lsu_issue_t issue;
        lsu_pkg::cdb_t       want;
        pending_store_t      st;
        int                  waited;
        rnd         = next_rand();
        imm12       = rnd[11:0];
        imm         = {{20{imm12[11]}}, imm12};
        issue.tag   = rnd[17:12];
        issue.src_a = target - imm;
        if (is_store) begin
            issue.opcode = lsu_pkg::OPCODE_STORE;
            issue.insn   = {imm12[11:5], 5'd3, 5'd1, funct3, imm12[4:0], 7'b0100011};
            issue.src_b  = wdata;
        end else begin
            issue.opcode = lsu_pkg::OPCODE_LOAD;
            issue.insn   = {imm12, 5'd1, funct3, 5'd2, 7'b0000011};
            issue.src_b  = next_rand();
        end
        i_fu_issue = issue;
        i_fu_valid = 1'b1;
        waited     = 0;
        @(negedge clk);
        while (o_fu_stall !== 1'b0) begin
            waited++;
            if (waited >= 200) begin
                fail_run("issue held off by o_fu_stall for 200 cycles");
            end
            @(negedge clk);
        end
        want.tag  = issue.tag;
        want.addr = target;
        want.data = is_store ? '0 : load_ref(funct3, target);
        exp_q.push_back(want);
        name_q.push_back(cur_test);
        exp_edge_q.push_back(edge_cnt + 1);
        if (is_store) begin
            st.funct3 = funct3;
            st.addr   = target;
            st.data   = wdata;
            st.tag    = issue.tag;
            store_q.push_back(st);
        end
        last_wait = waited;
        @(posedge clk);
        #1;
        i_fu_valid = 1'b0;
    endtask

    task automatic retire_oldest();
        pending_store_t st;
        int             waited;
        if (store_q.size() == 0) begin
            fail_run("no unretired store left to retire");
        end
        st               = store_q[0];
        i_rob_retire_en  = 1'b1;
        i_rob_retire_tag = st.tag;
        waited           = 0;
        @(negedge clk);
        while (o_rob_retire_stall !== 1'b0) begin
            waited++;
            if (waited >= 200) begin
                fail_run("retire held off by o_rob_retire_stall for 200 cycles");
            end
            @(negedge clk);
        end
        apply_store(st);
        void'(store_q.pop_front());
        @(posedge clk);
        #1;
        i_rob_retire_en = 1'b0;
    endtask

    // Whatever was accepted at the edge just passed is still in ID->EX and is lost
    task automatic flush_pipe();
        i_flush = 1'b1;
        while (exp_edge_q.size() > 0 && exp_edge_q[$] >= edge_cnt) begin
            void'(exp_q.pop_back());
            void'(name_q.pop_back());
            void'(exp_edge_q.pop_back());
        end
        store_q.delete();
        @(posedge clk);
        #1;
        i_flush = 1'b0;
        @(negedge clk);
        if (o_rob_retire_stall !== 1'b1) begin
            fail_run("o_rob_retire_stall is low on the empty store queue after flush");
        end
        @(posedge clk);
        #1;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited >= 200) begin
                fail_run("expected CDB broadcasts did not arrive within 200 cycles");
            end
        end
        repeat (2) @(posedge clk);
        #1;
    endtask

    initial begin : stimulus
        lsu_pkg::addr_t a;
        lsu_pkg::addr_t b;
        logic [2:0]     f;
        n_rst            = 1'b0;
        i_flush          = 1'b0;
        i_fu_valid       = 1'b0;
        i_fu_issue       = '0;
        i_rob_retire_en  = 1'b0;
        i_rob_retire_tag = '0;
        repeat (8) @(posedge clk);
        #1;
        n_rst = 1'b1;
        @(negedge clk);
        if (o_cdb_en !== 1'b0 || o_fu_stall !== 1'b0) begin
            fail_run("o_cdb_en or o_fu_stall is not low after reset");
        end
        @(posedge clk);
        #1;

        // Every word of the window gets a retired SW first
        cur_test = "fill";
        for (int w = 0; w < 16; w++) begin
            issue_op(1'b1, 3'b010, 32'(w * 4), next_rand());
            retire_oldest();
        end
        wait_drain();

        cur_test = "load_widths";
        for (int k = 0; k < 25; k++) begin
            f = load_f3[k % 5];
            issue_op(1'b0, f, random_target(f), '0);
        end
        wait_drain();

        cur_test = "store_unretired";
        a = random_target(3'b010);
        issue_op(1'b1, 3'b010, a, next_rand());
        issue_op(1'b0, 3'b010, a, '0);
        issue_op(1'b0, 3'b100, a, '0);
        retire_oldest();
        issue_op(1'b0, 3'b010, a, '0);
        wait_drain();

        cur_test = "merge_bytes";
        a = random_target(3'b010);
        b = a ^ 32'h20;
        issue_op(1'b1, 3'b000, a + 1, next_rand());
        issue_op(1'b1, 3'b001, a + 2, next_rand());
        issue_op(1'b1, 3'b010, b, next_rand());
        while (store_q.size() > 0) begin
            retire_oldest();
        end
        issue_op(1'b0, 3'b010, a, '0);
        issue_op(1'b0, 3'b000, a + 1, '0);
        issue_op(1'b0, 3'b101, a + 2, '0);
        issue_op(1'b0, 3'b001, a + 2, '0);
        issue_op(1'b0, 3'b010, b, '0);
        wait_drain();

        cur_test = "queue_full";
        for (int k = 0; k < `LSU_SQ_DEPTH; k++) begin
            f = 3'(next_rand() % 3);
            issue_op(1'b1, f, random_target(f), next_rand());
        end
        @(negedge clk);
        if (o_fu_stall !== 1'b1) begin
            fail_run("o_fu_stall is low with a full store queue");
        end
        @(posedge clk);
        #1;
        fork
            issue_op(1'b1, 3'b010, random_target(3'b010), next_rand());
            begin
                repeat (3) @(posedge clk);
                #1;
                retire_oldest();
            end
        join
        if (last_wait < 3) begin
            fail_run("fifth store was accepted while the store queue was full");
        end
        while (store_q.size() > 0) begin
            retire_oldest();
        end
        wait_drain();

        cur_test = "load_stream";
        for (int w = 0; w < 16; w++) begin
            issue_op(1'b0, 3'b010, 32'(w * 4), '0);
        end
        for (int k = 0; k < 16; k++) begin
            f = load_f3[next_rand() % 5];
            issue_op(1'b0, f, random_target(f), '0);
        end
        wait_drain();

        cur_test = "flush";
        a = random_target(3'b010);
        b = a ^ 32'h10;
        issue_op(1'b1, 3'b010, a, next_rand());
        issue_op(1'b1, 3'b010, b, next_rand());
        issue_op(1'b0, 3'b010, a, '0);
        issue_op(1'b0, 3'b010, b, '0);
        flush_pipe();
        wait_drain();
        issue_op(1'b0, 3'b010, a, '0);
        issue_op(1'b0, 3'b010, b, '0);
        issue_op(1'b0, 3'b101, a, '0);
        wait_drain();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+include
src/lsu_pkg.sv
src/lsu_id.sv
src/lsu_sq.sv
src/lsu_dmem.sv
src/lsu_ex.sv
src/lsu.sv
verification/lsu_tb.sv
